//--- files.f
gcu_pkg.sv
gcu_bus_ctrl.sv
gcu_scroll_regs.sv
gcu_vram.sv
gcu_video_timing.sv
gcu_top.sv
tb_gcu.sv

//--- gcu_bus_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~
// CPU bus sequencer: turns the op strobes into register pulses,
// owns the VRAM pointer and runs the RAM write and read sequences.
// ack drops for one cycle on a write and two on a read
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module gcu_bus_ctrl (
    input  logic                       CLK96,
    input  logic                       RESET96,
    input  logic                       op_select_reg,
    input  logic                       op_write_reg,
    input  logic                       op_write_ram,
    input  logic                       op_read_ram_h,
    input  logic                       op_read_ram_l,
    input  logic                       op_set_ram_ptr,
    input  logic [gcu_pkg::data_w-1:0] din,
    input  logic [gcu_pkg::data_w-1:0] ram_q,
    output logic                       ack,
    output logic [gcu_pkg::data_w-1:0] dout,
    output logic                       sel_wr,
    output logic                       reg_wr,
    output logic [gcu_pkg::data_w-1:0] reg_din,
    output logic                       ram_we,
    output logic [gcu_pkg::addr_w-1:0] ram_addr,
    output logic [gcu_pkg::data_w-1:0] ram_din
);

    gcu_pkg::gcu_op_e           op;
    gcu_pkg::gcu_op_e           last_op;
    logic [gcu_pkg::data_w-1:0] ram_ptr;
    logic [1:0]                 rd_step;
    logic                       wr_done;

    // priority decode of the strobes
    always_comb begin
        if (op_select_reg)
            op = gcu_pkg::OP_SELECT_REG;
        else if (op_write_reg)
            op = gcu_pkg::OP_WRITE_REG;
        else if (op_set_ram_ptr)
            op = gcu_pkg::OP_SET_PTR;
        else if (op_write_ram)
            op = gcu_pkg::OP_WRITE_RAM;
        else if (op_read_ram_h)
            op = gcu_pkg::OP_READ_RAM_H;
        else if (op_read_ram_l)
            op = gcu_pkg::OP_READ_RAM_L;
        else
            op = gcu_pkg::OP_IDLE;
    end

    // register ops act once, on the first edge of a held strobe
    assign sel_wr  = (op == gcu_pkg::OP_SELECT_REG) && (last_op != gcu_pkg::OP_SELECT_REG);
    assign reg_wr  = (op == gcu_pkg::OP_WRITE_REG) && (last_op != gcu_pkg::OP_WRITE_REG);
    assign reg_din = din;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            last_op  <= gcu_pkg::OP_IDLE;
            ack      <= 1'b1;
            dout     <= '0;
            ram_ptr  <= '0;
            rd_step  <= '0;
            wr_done  <= 1'b0;
            ram_we   <= 1'b0;
            ram_addr <= '0;
            ram_din  <= '0;
        end else begin
            last_op <= op;
            // new op restarts the sequences
            if (op != last_op) begin
                rd_step <= '0;
                wr_done <= 1'b0;
                ram_we  <= 1'b0;
                ack     <= 1'b1;
            end
            case (op)
                gcu_pkg::OP_SET_PTR: begin
                    ram_ptr <= din;
                end
                gcu_pkg::OP_WRITE_RAM: begin
                    if (!wr_done) begin
                        ram_addr <= ram_ptr[gcu_pkg::addr_w-1:0];
                        ram_din  <= din;
                        ram_we   <= 1'b1;
                        wr_done  <= 1'b1;
                        ack      <= 1'b0;
                    end else if (!ack) begin
                        ram_we  <= 1'b0;
                        ram_ptr <= ram_ptr + 1'b1;
                        ack     <= 1'b1;
                    end
                end
                gcu_pkg::OP_READ_RAM_H, gcu_pkg::OP_READ_RAM_L: begin
                    case (rd_step)
                        2'd0: begin
                            // low half sits one word above the pointer
                            ram_addr <= ram_ptr[gcu_pkg::addr_w-1:0]
                                      + gcu_pkg::addr_w'(op == gcu_pkg::OP_READ_RAM_L);
                            ack      <= 1'b0;
                            rd_step  <= 2'd1;
                        end
                        2'd1: rd_step <= 2'd2;
                        2'd2: begin
                            dout    <= ram_q;
                            ack     <= 1'b1;
                            rd_step <= 2'd3;
                        end
                        default: ;
                    endcase
                end
                gcu_pkg::OP_IDLE: begin
                    ram_we  <= 1'b0;
                    wr_done <= 1'b0;
                    rd_step <= '0;
                    ack     <= 1'b1;
                end
                default: ack <= 1'b1;
            endcase
        end
    end

    // CPU drives at most one strobe at a time
    a_ops_onehot: assert property (@(posedge CLK96) disable iff (RESET96)
        $onehot0({op_select_reg, op_write_reg, op_set_ram_ptr,
                  op_write_ram, op_read_ram_h, op_read_ram_l}));

endmodule

//--- gcu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// shared widths, VRAM address map, register indices and op codes
// for the graphics control unit core; blocks refer to these
// through gcu_pkg:: scoped names
// ~~~~~~~~~~~~~~~~~~~~
package gcu_pkg;

    // bus and memory widths
    localparam int data_w    = 16;
    localparam int addr_w    = 13;
    localparam int scroll_w  = 13;
    localparam int layer_aw  = 11;
    localparam int sprite_aw = 10;
    localparam int pos_w     = 9;
    localparam int reg_idx_w = 8;

    // select keeps the alias bit and the low nibble only
    localparam logic [reg_idx_w-1:0] reg_sel_mask = 8'h8F;

    // VRAM windows, each mirrored into its own RAM
    localparam logic [addr_w-1:0] scr0_base   = 13'h0000;
    localparam logic [addr_w-1:0] scr1_base   = 13'h0800;
    localparam logic [addr_w-1:0] scr2_base   = 13'h1000;
    localparam logic [addr_w-1:0] sprite_base = 13'h1800;
    localparam logic [addr_w-1:0] sprite_end  = 13'h1C00;

    // line on which the vertical interrupt is raised
    localparam logic [pos_w-1:0] vint_line = 9'h0E6;

    typedef enum logic [2:0] {
        OP_IDLE,
        OP_SELECT_REG,
        OP_WRITE_REG,
        OP_SET_PTR,
        OP_WRITE_RAM,
        OP_READ_RAM_H,
        OP_READ_RAM_L
    } gcu_op_e;

    typedef enum logic [reg_idx_w-1:0] {
        REG_BG_X     = 8'h00,
        REG_BG_Y     = 8'h01,
        REG_FG_X     = 8'h02,
        REG_FG_Y     = 8'h03,
        REG_TX_X     = 8'h04,
        REG_TX_Y     = 8'h05,
        REG_SP_X     = 8'h06,
        REG_SP_Y     = 8'h07,
        REG_INIT_V   = 8'h0E,
        REG_VINT_ACK = 8'h0F
    } gcu_reg_e;

endpackage

//--- gcu_scroll_regs.sv
// ~~~~~~~~~~~~~~~~~~~~
// scroll register file: holds the selected index and the eight
// layer scroll values; also flags indices that hold the vertical
// interrupt off
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module gcu_scroll_regs (
    input  logic                                CLK96,
    input  logic                                RESET96,
    input  logic                                sel_wr,
    input  logic                                reg_wr,
    input  logic [gcu_pkg::data_w-1:0]          reg_din,
    output logic signed [gcu_pkg::scroll_w-1:0] bg_scroll_x,
    output logic signed [gcu_pkg::scroll_w-1:0] bg_scroll_y,
    output logic signed [gcu_pkg::scroll_w-1:0] fg_scroll_x,
    output logic signed [gcu_pkg::scroll_w-1:0] fg_scroll_y,
    output logic signed [gcu_pkg::scroll_w-1:0] tx_scroll_x,
    output logic signed [gcu_pkg::scroll_w-1:0] tx_scroll_y,
    output logic signed [gcu_pkg::scroll_w-1:0] sp_scroll_x,
    output logic signed [gcu_pkg::scroll_w-1:0] sp_scroll_y,
    output logic                                vint_hold
);

    logic [gcu_pkg::reg_idx_w-1:0] sel_idx;
    logic [6:0]                    idx_lo;
    logic [gcu_pkg::scroll_w-1:0]  scroll_q [0:7];

    // bit 7 only aliases the lower indices
    assign idx_lo = sel_idx[6:0];

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            sel_idx <= '1;
            for (int i = 0; i < 8; i++) begin
                scroll_q[i] <= '0;
            end
        end else begin
            if (sel_wr)
                sel_idx <= reg_din[gcu_pkg::reg_idx_w-1:0] & gcu_pkg::reg_sel_mask;
            if (reg_wr) begin
                if (idx_lo <= 7'(gcu_pkg::REG_SP_Y))
                    scroll_q[idx_lo[2:0]] <= reg_din[gcu_pkg::scroll_w-1:0];
            end
        end
    end

    // x/y pairs in layer order
    assign bg_scroll_x = scroll_q[0];
    assign bg_scroll_y = scroll_q[1];
    assign fg_scroll_x = scroll_q[2];
    assign fg_scroll_y = scroll_q[3];
    assign tx_scroll_x = scroll_q[4];
    assign tx_scroll_y = scroll_q[5];
    assign sp_scroll_x = scroll_q[6];
    assign sp_scroll_y = scroll_q[7];

    // 0x0E, 0x0F and 0x8F keep VINT low
    assign vint_hold = (sel_idx == gcu_pkg::REG_INIT_V)
                    || (idx_lo == 7'(gcu_pkg::REG_VINT_ACK));

endmodule

//--- gcu_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// graphics control unit core: CPU bus sequencer, scroll registers,
// VRAM with renderer ports and video timing, all on CLK96
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module gcu_top (
    input  logic                                CLK96,
    input  logic                                RESET96,
    input  logic                                op_select_reg,
    input  logic                                op_write_reg,
    input  logic                                op_write_ram,
    input  logic                                op_read_ram_h,
    input  logic                                op_read_ram_l,
    input  logic                                op_set_ram_ptr,
    input  logic [gcu_pkg::data_w-1:0]          din,
    input  logic [gcu_pkg::pos_w-1:0]           h,
    input  logic [gcu_pkg::pos_w-1:0]           v,
    input  logic [gcu_pkg::pos_w-1:0]           hs_start,
    input  logic [gcu_pkg::pos_w-1:0]           hs_end,
    input  logic [gcu_pkg::pos_w-1:0]           vs_start,
    input  logic [gcu_pkg::pos_w-1:0]           vs_end,
    input  logic [gcu_pkg::layer_aw-1:0]        scr0_addr,
    input  logic [gcu_pkg::layer_aw-1:0]        scr1_addr,
    input  logic [gcu_pkg::layer_aw-1:0]        scr2_addr,
    input  logic [gcu_pkg::sprite_aw-1:0]       sprite_addr,
    output logic                                ack,
    output logic [gcu_pkg::data_w-1:0]          dout,
    output logic                                hsync,
    output logic                                vsync,
    output logic                                fblank,
    output logic                                vint,
    output logic signed [gcu_pkg::scroll_w-1:0] bg_scroll_x,
    output logic signed [gcu_pkg::scroll_w-1:0] bg_scroll_y,
    output logic signed [gcu_pkg::scroll_w-1:0] fg_scroll_x,
    output logic signed [gcu_pkg::scroll_w-1:0] fg_scroll_y,
    output logic signed [gcu_pkg::scroll_w-1:0] tx_scroll_x,
    output logic signed [gcu_pkg::scroll_w-1:0] tx_scroll_y,
    output logic signed [gcu_pkg::scroll_w-1:0] sp_scroll_x,
    output logic signed [gcu_pkg::scroll_w-1:0] sp_scroll_y,
    output logic [gcu_pkg::data_w-1:0]          scr0_dout,
    output logic [gcu_pkg::data_w-1:0]          scr1_dout,
    output logic [gcu_pkg::data_w-1:0]          scr2_dout,
    output logic [gcu_pkg::data_w-1:0]          sprite_dout
);

    logic                       sel_wr;
    logic                       reg_wr;
    logic [gcu_pkg::data_w-1:0] reg_din;
    logic                       ram_we;
    logic [gcu_pkg::addr_w-1:0] ram_addr;
    logic [gcu_pkg::data_w-1:0] ram_din;
    logic [gcu_pkg::data_w-1:0] ram_q;
    logic                       vint_hold;

    gcu_bus_ctrl u_bus_ctrl (
        .CLK96          (CLK96),
        .RESET96        (RESET96),
        .op_select_reg  (op_select_reg),
        .op_write_reg   (op_write_reg),
        .op_write_ram   (op_write_ram),
        .op_read_ram_h  (op_read_ram_h),
        .op_read_ram_l  (op_read_ram_l),
        .op_set_ram_ptr (op_set_ram_ptr),
        .din            (din),
        .ram_q          (ram_q),
        .ack            (ack),
        .dout           (dout),
        .sel_wr         (sel_wr),
        .reg_wr         (reg_wr),
        .reg_din        (reg_din),
        .ram_we         (ram_we),
        .ram_addr       (ram_addr),
        .ram_din        (ram_din)
    );

    gcu_scroll_regs u_scroll_regs (
        .CLK96       (CLK96),
        .RESET96     (RESET96),
        .sel_wr      (sel_wr),
        .reg_wr      (reg_wr),
        .reg_din     (reg_din),
        .bg_scroll_x (bg_scroll_x),
        .bg_scroll_y (bg_scroll_y),
        .fg_scroll_x (fg_scroll_x),
        .fg_scroll_y (fg_scroll_y),
        .tx_scroll_x (tx_scroll_x),
        .tx_scroll_y (tx_scroll_y),
        .sp_scroll_x (sp_scroll_x),
        .sp_scroll_y (sp_scroll_y),
        .vint_hold   (vint_hold)
    );

    gcu_vram u_vram (
        .CLK96       (CLK96),
        .ram_we      (ram_we),
        .ram_addr    (ram_addr),
        .ram_din     (ram_din),
        .scr0_addr   (scr0_addr),
        .scr1_addr   (scr1_addr),
        .scr2_addr   (scr2_addr),
        .sprite_addr (sprite_addr),
        .ram_q       (ram_q),
        .scr0_dout   (scr0_dout),
        .scr1_dout   (scr1_dout),
        .scr2_dout   (scr2_dout),
        .sprite_dout (sprite_dout)
    );

    gcu_video_timing u_video_timing (
        .CLK96     (CLK96),
        .RESET96   (RESET96),
        .h         (h),
        .v         (v),
        .hs_start  (hs_start),
        .hs_end    (hs_end),
        .vs_start  (vs_start),
        .vs_end    (vs_end),
        .vint_hold (vint_hold),
        .hsync     (hsync),
        .vsync     (vsync),
        .fblank    (fblank),
        .vint      (vint)
    );

endmodule

//--- gcu_video_timing.sv
// ~~~~~~~~~~~~~~~~~~~~
// registered sync, blank and vertical interrupt lines, compared
// against the incoming H/V counters and window bounds
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module gcu_video_timing (
    input  logic                      CLK96,
    input  logic                      RESET96,
    input  logic [gcu_pkg::pos_w-1:0] h,
    input  logic [gcu_pkg::pos_w-1:0] v,
    input  logic [gcu_pkg::pos_w-1:0] hs_start,
    input  logic [gcu_pkg::pos_w-1:0] hs_end,
    input  logic [gcu_pkg::pos_w-1:0] vs_start,
    input  logic [gcu_pkg::pos_w-1:0] vs_end,
    input  logic                      vint_hold,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      fblank,
    output logic                      vint
);

    logic in_hs;
    logic in_vs;

    // horizontal window is open, vertical is closed
    assign in_hs = (h > hs_start) && (h < hs_end);
    assign in_vs = (v >= vs_start) && (v <= vs_end);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            hsync  <= 1'b1;
            vsync  <= 1'b1;
            fblank <= 1'b1;
            vint   <= 1'b0;
        end else begin
            hsync  <= !in_hs;
            vsync  <= !in_vs;
            fblank <= !(in_hs || in_vs);
            vint   <= !((v == gcu_pkg::vint_line) || vint_hold);
        end
    end

    a_vint_line: assert property (@(posedge CLK96) disable iff (RESET96)
        (v == gcu_pkg::vint_line) |=> !vint);

endmodule

//--- gcu_vram.sv
// ~~~~~~~~~~~~~~~~~~~~
// 8K-word VRAM for the CPU side plus one mirror RAM per window
// (three scroll layers and sprites) so each renderer has its own
// read port; all reads are registered
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module gcu_vram (
    input  logic                          CLK96,
    input  logic                          ram_we,
    input  logic [gcu_pkg::addr_w-1:0]    ram_addr,
    input  logic [gcu_pkg::data_w-1:0]    ram_din,
    input  logic [gcu_pkg::layer_aw-1:0]  scr0_addr,
    input  logic [gcu_pkg::layer_aw-1:0]  scr1_addr,
    input  logic [gcu_pkg::layer_aw-1:0]  scr2_addr,
    input  logic [gcu_pkg::sprite_aw-1:0] sprite_addr,
    output logic [gcu_pkg::data_w-1:0]    ram_q,
    output logic [gcu_pkg::data_w-1:0]    scr0_dout,
    output logic [gcu_pkg::data_w-1:0]    scr1_dout,
    output logic [gcu_pkg::data_w-1:0]    scr2_dout,
    output logic [gcu_pkg::data_w-1:0]    sprite_dout
);

    // window bounds, upper bound exclusive
    localparam logic [gcu_pkg::addr_w-1:0] win_lo [0:3] = '{
        gcu_pkg::scr0_base, gcu_pkg::scr1_base, gcu_pkg::scr2_base, gcu_pkg::sprite_base};
    localparam logic [gcu_pkg::addr_w-1:0] win_hi [0:3] = '{
        gcu_pkg::scr1_base, gcu_pkg::scr2_base, gcu_pkg::sprite_base, gcu_pkg::sprite_end};

    logic [gcu_pkg::data_w-1:0]   main_mem [0:(1 << gcu_pkg::addr_w)-1];
    logic [3:0]                   win_we;
    logic [gcu_pkg::layer_aw-1:0] rd_addr [0:3];
    logic [gcu_pkg::data_w-1:0]   rd_q [0:3];

    always_ff @(posedge CLK96) begin
        if (ram_we)
            main_mem[ram_addr] <= ram_din;
        ram_q <= main_mem[ram_addr];
    end

    assign rd_addr[0] = scr0_addr;
    assign rd_addr[1] = scr1_addr;
    assign rd_addr[2] = scr2_addr;
    assign rd_addr[3] = gcu_pkg::layer_aw'(sprite_addr);

    genvar g;
    generate
        for (g = 0; g < 4; g++) begin : g_mirror
            // sprite window is half the size of a scroll layer
            localparam int aw = (g == 3) ? gcu_pkg::sprite_aw : gcu_pkg::layer_aw;
            logic [gcu_pkg::data_w-1:0] mem [0:(1 << aw)-1];

            assign win_we[g] = ram_we && (ram_addr >= win_lo[g]) && (ram_addr < win_hi[g]);

            // bases are window aligned, so low bits give the offset
            always_ff @(posedge CLK96) begin
                if (win_we[g])
                    mem[ram_addr[aw-1:0]] <= ram_din;
                rd_q[g] <= mem[rd_addr[g][aw-1:0]];
            end
        end
    endgenerate

    assign scr0_dout   = rd_q[0];
    assign scr1_dout   = rd_q[1];
    assign scr2_dout   = rd_q[2];
    assign sprite_dout = rd_q[3];

    a_one_mirror: assert property (@(posedge CLK96) $onehot0(win_we));

endmodule

//--- run_sim.sh
#!/bin/sh
# build the GCU testbench with Verilator, run it and scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_gcu -f files.f \
    || { echo "build failed"; exit 1; }
./obj_dir/Vtb_gcu > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; } \
    || { echo "simulation finished without failure"; exit 0; }

//--- tb_gcu.sv
// ~~~~~~~~~~~~~~~~~~~~
// testbench for the GCU core: random CPU ops, VRAM traffic and
// video timing inputs, checked against a reference model of the
// registers, pointer and VRAM; stops at the first mismatch
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_gcu;

    logic CLK96;
    logic RESET96;
    logic op_select_reg, op_write_reg, op_write_ram;
    logic op_read_ram_h, op_read_ram_l, op_set_ram_ptr;
    logic [gcu_pkg::data_w-1:0] din;
    logic [gcu_pkg::pos_w-1:0] h, v, hs_start, hs_end, vs_start, vs_end;
    logic [gcu_pkg::layer_aw-1:0] scr0_addr, scr1_addr, scr2_addr;
    logic [gcu_pkg::sprite_aw-1:0] sprite_addr;
    logic ack, hsync, vsync, fblank, vint;
    logic [gcu_pkg::data_w-1:0] dout, scr0_dout, scr1_dout, scr2_dout, sprite_dout;
    logic signed [gcu_pkg::scroll_w-1:0] bg_scroll_x, bg_scroll_y, fg_scroll_x, fg_scroll_y;
    logic signed [gcu_pkg::scroll_w-1:0] tx_scroll_x, tx_scroll_y, sp_scroll_x, sp_scroll_y;

    // reference model state
    logic signed [gcu_pkg::scroll_w-1:0] model_scroll [0:7];
    logic [gcu_pkg::reg_idx_w-1:0]       model_sel;
    logic [gcu_pkg::data_w-1:0]          model_ptr;
    logic [gcu_pkg::data_w-1:0]          model_mem [0:(1 << gcu_pkg::addr_w)-1];

    integer seed;
    int     n_checks;

    gcu_top dut0 (.*);

    always #2 CLK96 = ~CLK96;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_scroll(input string name, input logic signed [gcu_pkg::scroll_w-1:0] exp,
                                input logic signed [gcu_pkg::scroll_w-1:0] act);
        n_checks++;
        if (act !== exp)
            abort_run($sformatf("FAIL %0t %s expected %0d got %0d", $time, name, exp, act));
    endtask

    task automatic check_word(input string name, input logic [gcu_pkg::data_w-1:0] exp,
                              input logic [gcu_pkg::data_w-1:0] act);
        n_checks++;
        if (act !== exp)
            abort_run($sformatf("FAIL %0t %s expected %h got %h", $time, name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        n_checks++;
        if (act !== exp)
            abort_run($sformatf("FAIL %0t %s expected %b got %b", $time, name, exp, act));
    endtask

    task automatic check_scrolls();
        check_scroll("bg_scroll_x", model_scroll[0], bg_scroll_x);
        check_scroll("bg_scroll_y", model_scroll[1], bg_scroll_y);
        check_scroll("fg_scroll_x", model_scroll[2], fg_scroll_x);
        check_scroll("fg_scroll_y", model_scroll[3], fg_scroll_y);
        check_scroll("tx_scroll_x", model_scroll[4], tx_scroll_x);
        check_scroll("tx_scroll_y", model_scroll[5], tx_scroll_y);
        check_scroll("sp_scroll_x", model_scroll[6], sp_scroll_x);
        check_scroll("sp_scroll_y", model_scroll[7], sp_scroll_y);
    endtask

    // one CPU op from a falling edge, followed by one idle cycle
    task automatic cpu_op(input gcu_pkg::gcu_op_e kind, input logic [gcu_pkg::data_w-1:0] word);
        int                         n_low;
        int                         waited;
        logic [gcu_pkg::addr_w-1:0] addr;
        logic [6:0]                 idx;
        n_low  = 0;
        waited = 0;
        addr   = model_ptr[gcu_pkg::addr_w-1:0];
        if (kind == gcu_pkg::OP_READ_RAM_L)
            addr = addr + 13'd1;
        din            = word;
        op_select_reg  = (kind == gcu_pkg::OP_SELECT_REG);
        op_write_reg   = (kind == gcu_pkg::OP_WRITE_REG);
        op_set_ram_ptr = (kind == gcu_pkg::OP_SET_PTR);
        op_write_ram   = (kind == gcu_pkg::OP_WRITE_RAM);
        op_read_ram_h  = (kind == gcu_pkg::OP_READ_RAM_H);
        op_read_ram_l  = (kind == gcu_pkg::OP_READ_RAM_L);
        @(negedge CLK96);
        if (kind inside {gcu_pkg::OP_WRITE_RAM, gcu_pkg::OP_READ_RAM_H, gcu_pkg::OP_READ_RAM_L}) begin
            while (ack !== 1'b0) begin
                if (waited >= 8)
                    abort_run("timeout: ack never went low during a RAM access");
                else begin
                    @(negedge CLK96);
                    waited++;
                end
            end
            while (ack === 1'b0) begin
                if (waited >= 16)
                    abort_run("timeout: ack stayed low after a RAM access");
                else begin
                    @(negedge CLK96);
                    waited++;
                    n_low++;
                end
            end
            // writes hold ack low one cycle, reads two
            check_word("ack low cycles", (kind == gcu_pkg::OP_WRITE_RAM) ? 16'd1 : 16'd2,
                       16'(n_low));
            if (kind == gcu_pkg::OP_WRITE_RAM) begin
                model_mem[addr] = word;
                model_ptr       = model_ptr + 16'd1;
            end else
                check_word("dout", model_mem[addr], dout);
        end else begin
            check_bit("ack", 1'b1, ack);
            if (kind == gcu_pkg::OP_SELECT_REG)
                model_sel = word[gcu_pkg::reg_idx_w-1:0] & gcu_pkg::reg_sel_mask;
            else if (kind == gcu_pkg::OP_SET_PTR)
                model_ptr = word;
            else begin
                // alias bit 7 is ignored on writes
                idx = model_sel[6:0];
                if (idx <= 7'd7)
                    model_scroll[idx[2:0]] = word[gcu_pkg::scroll_w-1:0];
            end
        end
        {op_select_reg, op_write_reg, op_set_ram_ptr} = 3'b000;
        {op_write_ram, op_read_ram_h, op_read_ram_l}  = 3'b000;
        @(negedge CLK96);
    endtask

    // write one word inside a window and read it back on its renderer port
    task automatic mirror_check(input int w);
        logic [gcu_pkg::addr_w-1:0] base;
        logic [gcu_pkg::addr_w-1:0] addr;
        case (w)
            0: base = gcu_pkg::scr0_base;
            1: base = gcu_pkg::scr1_base;
            2: base = gcu_pkg::scr2_base;
            default: base = gcu_pkg::sprite_base;
        endcase
        addr = base + (13'($random(seed)) & ((w == 3) ? 13'h03FF : 13'h07FF));
        cpu_op(gcu_pkg::OP_SET_PTR, {3'($random(seed)), addr});
        cpu_op(gcu_pkg::OP_WRITE_RAM, 16'($random(seed)));
        case (w)
            0: scr0_addr = 11'(addr - base);
            1: scr1_addr = 11'(addr - base);
            2: scr2_addr = 11'(addr - base);
            default: sprite_addr = 10'(addr - base);
        endcase
        @(negedge CLK96);
        case (w)
            0: check_word("scr0_dout", model_mem[addr], scr0_dout);
            1: check_word("scr1_dout", model_mem[addr], scr1_dout);
            2: check_word("scr2_dout", model_mem[addr], scr2_dout);
            default: check_word("sprite_dout", model_mem[addr], sprite_dout);
        endcase
    endtask

    // random counters near random windows, outputs due one cycle later
    task automatic video_step();
        logic exp_hs;
        logic exp_vs;
        logic hold;
        hs_start = 9'($random(seed));
        hs_end   = hs_start + 9'(6'($random(seed)));
        h        = hs_start + 9'(6'($random(seed)));
        vs_start = 9'($random(seed));
        vs_end   = vs_start + 9'(6'($random(seed)));
        v        = vs_start + 9'(6'($random(seed)));
        if (3'($random(seed)) == 3'd0)
            v = gcu_pkg::vint_line;
        exp_hs = !((h > hs_start) && (h < hs_end));
        exp_vs = !((v >= vs_start) && (v <= vs_end));
        hold   = (model_sel == 8'h0E) || (model_sel == 8'h0F) || (model_sel == 8'h8F);
        @(negedge CLK96);
        check_bit("hsync", exp_hs, hsync);
        check_bit("vsync", exp_vs, vsync);
        check_bit("fblank", exp_hs && exp_vs, fblank);
        check_bit("vint", !((v == gcu_pkg::vint_line) || hold), vint);
    endtask

    initial begin : main
        int                         k;
        logic [gcu_pkg::data_w-1:0] base;
        logic [gcu_pkg::data_w-1:0] sel_word;
        seed     = 32'hb8b6;
        n_checks = 0;
        CLK96    = 1'b0;
        RESET96  = 1'b1;
        {op_select_reg, op_write_reg, op_set_ram_ptr} = 3'b000;
        {op_write_ram, op_read_ram_h, op_read_ram_l}  = 3'b000;
        din = '0;
        {h, v, hs_start, hs_end, vs_start, vs_end} = '0;
        {scr0_addr, scr1_addr, scr2_addr, sprite_addr} = '0;
        for (int i = 0; i < 8; i++)
            model_scroll[i] = '0;
        model_sel = 8'hFF;
        model_ptr = '0;

        repeat (3) @(posedge CLK96);
        @(negedge CLK96);
        check_bit("ack", 1'b1, ack);
        check_bit("hsync", 1'b1, hsync);
        check_bit("vsync", 1'b1, vsync);
        check_bit("fblank", 1'b1, fblank);
        check_bit("vint", 1'b0, vint);
        check_scrolls();
        RESET96 = 1'b0;
        @(negedge CLK96);

        // scroll registers, index may carry the alias bit
        for (int i = 0; i < 40; i++) begin
            cpu_op(gcu_pkg::OP_SELECT_REG, 16'($random(seed)));
            cpu_op(gcu_pkg::OP_WRITE_REG, 16'($random(seed)));
            check_scrolls();
        end

        // write bursts, then read back inside each burst
        for (int b = 0; b < 6; b++) begin
            base = 16'($random(seed));
            cpu_op(gcu_pkg::OP_SET_PTR, base);
            for (int i = 0; i < 8; i++)
                cpu_op(gcu_pkg::OP_WRITE_RAM, 16'($random(seed)));
            for (int i = 0; i < 4; i++) begin
                k = int'({$random(seed)} % 7);
                cpu_op(gcu_pkg::OP_SET_PTR, base + 16'(k));
                cpu_op(gcu_pkg::OP_READ_RAM_H, 16'($random(seed)));
                cpu_op(gcu_pkg::OP_READ_RAM_L, 16'($random(seed)));
            end
        end

        for (int w = 0; w < 4; w++)
            repeat (6) mirror_check(w);

        // video timing, with the selected index moved now and then
        for (int i = 0; i < 200; i++) begin
            if (i % 16 == 0) begin
                sel_word = 16'($random(seed));
                case (2'($random(seed)))
                    2'd0: sel_word[7:0] = 8'h0E;
                    2'd1: sel_word[7:0] = 8'h0F;
                    2'd2: sel_word[7:0] = 8'hFF;
                    default: ;
                endcase
                cpu_op(gcu_pkg::OP_SELECT_REG, sel_word);
            end
            video_step();
        end

        if (n_checks == 0)
            abort_run("no checks were executed");
        else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule
